//--- logic/sign_crypt_pkg.sv
// shared widths and beat types; the sign bit is data bit 0 and the key is fixed at 64 bits
package sign_crypt_pkg;

	// one stream byte
	localparam int byte_w = 8;

	// key width and the width of the running bit index into it
	localparam int key_w = 64;
	localparam int key_idx_w = 6;

	// depth used by every FIFO unless the top level overrides it
	localparam int default_fifo_depth = 16;

	// output beat, and the payload of the internal paths
	typedef struct packed {
		logic [byte_w-1:0] data;
		// final byte of a stream
		logic last;
	} stream_beat_t;

	// input beat with the steering flag
	typedef struct packed {
		stream_beat_t beat;
		logic is_video;
	} tagged_beat_t;

	// order FIFO entry, 1 means the byte went down the video path
	typedef logic route_t;

endpackage

//--- logic/stream_fifo.sv
// single clock valid/ready FIFO; depth must be 2 or more, head entry is held while out_valid is high
`timescale 1ns/100ps

module stream_fifo #(
	parameter int depth = 4,
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst_n_200,

	input logic in_valid,
	output logic in_ready,
	input payload_t in_data,

	output logic out_valid,
	input logic out_ready,
	output payload_t out_data
);

	localparam int ptr_w = $clog2(depth);
	localparam int cnt_w = $clog2(depth + 1);

	payload_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic do_wr;
	logic do_rd;

	// wraps for depths that are not a power of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign in_ready = (count != cnt_w'(depth));
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];

	assign do_wr = in_valid & in_ready;
	assign do_rd = out_valid & out_ready;

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_200) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- logic/splitter.sv
// forks each input beat to one data path plus the order FIFO; input must hold its beat until taken
`timescale 1ns/100ps

module splitter (
	input logic clk,
	input logic rst_n_200,

	input logic in_valid,
	output logic in_ready,
	input sign_crypt_pkg::tagged_beat_t in_beat,

	output logic vid_valid,
	input logic vid_ready,
	output sign_crypt_pkg::stream_beat_t vid_beat,

	output logic misc_valid,
	input logic misc_ready,
	output sign_crypt_pkg::stream_beat_t misc_beat,

	output logic route_valid,
	input logic route_ready,
	output sign_crypt_pkg::route_t route
);

	// set once a branch has taken the current beat
	logic dest_done;
	logic route_done;
	logic dest_ok;
	logic route_ok;
	logic dest_xfer;

	assign vid_beat = in_beat.beat;
	assign misc_beat = in_beat.beat;
	assign route = in_beat.is_video;

	assign vid_valid = in_valid & in_beat.is_video & ~dest_done;
	assign misc_valid = in_valid & ~in_beat.is_video & ~dest_done;
	assign route_valid = in_valid & ~route_done;

	assign dest_ok = dest_done | (in_beat.is_video ? vid_ready : misc_ready);
	assign route_ok = route_done | route_ready;
	assign in_ready = dest_ok & route_ok;

	assign dest_xfer = (vid_valid & vid_ready) | (misc_valid & misc_ready);

	// a branch that is ready early is not written twice
	always_ff @(posedge clk) begin
		if (!rst_n_200) begin
			dest_done <= 1'b0;
			route_done <= 1'b0;
		end else if (in_valid && in_ready) begin
			dest_done <= 1'b0;
			route_done <= 1'b0;
		end else begin
			if (dest_xfer) begin
				dest_done <= 1'b1;
			end
			if (route_valid && route_ready) begin
				route_done <= 1'b1;
			end
		end
	end

endmodule

//--- logic/sign_scrambler.sv
// XORs data bit 0 of each video byte with a key bit; load the key only while no video byte is in flight
`timescale 1ns/100ps

module sign_scrambler (
	input logic clk,
	input logic rst_n_200,

	input logic [sign_crypt_pkg::key_w-1:0] key_in,
	input logic key_en,

	input logic in_valid,
	output logic in_ready,
	input sign_crypt_pkg::stream_beat_t in_beat,

	output logic out_valid,
	input logic out_ready,
	output sign_crypt_pkg::stream_beat_t out_beat
);

	logic [sign_crypt_pkg::key_w-1:0] key_reg;
	logic [sign_crypt_pkg::key_idx_w-1:0] key_idx;
	logic take;
	sign_crypt_pkg::stream_beat_t enc_beat;

	// the held beat can leave in the same cycle a new one arrives
	assign in_ready = ~out_valid | out_ready;
	assign take = in_valid & in_ready;

	always_comb begin
		enc_beat = in_beat;
		enc_beat.data[0] = in_beat.data[0] ^ key_reg[key_idx];
	end

	always_ff @(posedge clk) begin
		if (!rst_n_200) begin
			key_reg <= '0;
		end else if (key_en) begin
			key_reg <= key_in;
		end
	end

	// index wraps mod 64, restarts at each stream end
	always_ff @(posedge clk) begin
		if (!rst_n_200) begin
			key_idx <= '0;
		end else if (take) begin
			if (in_beat.last) begin
				key_idx <= '0;
			end else begin
				key_idx <= key_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_200) begin
			out_valid <= 1'b0;
		end else if (take) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out_beat <= enc_beat;
		end
	end

endmodule

//--- logic/joiner.sv
// rebuilds input order from the route tags; a route is held until its path yields the matching byte
`timescale 1ns/100ps

module joiner (
	input logic clk,
	input logic rst_n_200,

	input logic route_valid,
	output logic route_ready,
	input sign_crypt_pkg::route_t route,

	input logic vid_valid,
	output logic vid_ready,
	input sign_crypt_pkg::stream_beat_t vid_beat,

	input logic misc_valid,
	output logic misc_ready,
	input sign_crypt_pkg::stream_beat_t misc_beat,

	output logic out_valid,
	input logic out_ready,
	output sign_crypt_pkg::stream_beat_t out_beat
);

	logic route_held;
	sign_crypt_pkg::route_t route_reg;
	logic beat_done;

	// only the named path is looked at
	assign out_valid = route_held & (route_reg ? vid_valid : misc_valid);
	assign out_beat = route_reg ? vid_beat : misc_beat;

	assign vid_ready = route_held & route_reg & out_ready;
	assign misc_ready = route_held & ~route_reg & out_ready;

	assign beat_done = out_valid & out_ready;

	// next route can load as the current beat leaves
	assign route_ready = ~route_held | beat_done;

	always_ff @(posedge clk) begin
		if (!rst_n_200) begin
			route_held <= 1'b0;
		end else if (route_valid && route_ready) begin
			route_held <= 1'b1;
		end else if (beat_done) begin
			route_held <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (route_valid && route_ready) begin
			route_reg <= route;
		end
	end

endmodule

//--- logic/video_sign_crypt.sv
// sign bit scrambler top; variable latency, at best one byte per cycle, key loads only while idle
`timescale 1ns/100ps

module video_sign_crypt #(
	parameter int fifo_depth = sign_crypt_pkg::default_fifo_depth
) (
	input logic clk,
	input logic rst_n_200,

	input logic in_valid,
	output logic in_ready,
	input sign_crypt_pkg::tagged_beat_t in_beat,

	output logic out_valid,
	input logic out_ready,
	output sign_crypt_pkg::stream_beat_t out_beat,

	input logic [sign_crypt_pkg::key_w-1:0] key_in,
	input logic key_en
);

	// input FIFO to splitter
	logic inq_valid;
	logic inq_ready;
	sign_crypt_pkg::tagged_beat_t inq_beat;

	// splitter to the three FIFOs
	logic spl_vid_valid;
	logic spl_vid_ready;
	sign_crypt_pkg::stream_beat_t spl_vid_beat;
	logic spl_misc_valid;
	logic spl_misc_ready;
	sign_crypt_pkg::stream_beat_t spl_misc_beat;
	logic spl_route_valid;
	logic spl_route_ready;
	sign_crypt_pkg::route_t spl_route;

	// video FIFO to scrambler
	logic vid_valid;
	logic vid_ready;
	sign_crypt_pkg::stream_beat_t vid_beat;

	// scrambler to scrambled FIFO
	logic enc_valid;
	logic enc_ready;
	sign_crypt_pkg::stream_beat_t enc_beat;

	// FIFOs feeding the joiner
	logic scr_valid;
	logic scr_ready;
	sign_crypt_pkg::stream_beat_t scr_beat;
	logic misc_valid;
	logic misc_ready;
	sign_crypt_pkg::stream_beat_t misc_beat;
	logic ord_valid;
	logic ord_ready;
	sign_crypt_pkg::route_t ord_route;

	// joiner to output FIFO
	logic join_valid;
	logic join_ready;
	sign_crypt_pkg::stream_beat_t join_beat;

	stream_fifo #(.depth(fifo_depth), .payload_t(sign_crypt_pkg::tagged_beat_t)) i_in_fifo (
		.clk(clk), .rst_n_200(rst_n_200),
		.in_valid(in_valid), .in_ready(in_ready), .in_data(in_beat),
		.out_valid(inq_valid), .out_ready(inq_ready), .out_data(inq_beat)
	);

	splitter i_splitter (
		.clk(clk), .rst_n_200(rst_n_200),
		.in_valid(inq_valid), .in_ready(inq_ready), .in_beat(inq_beat),
		.vid_valid(spl_vid_valid), .vid_ready(spl_vid_ready), .vid_beat(spl_vid_beat),
		.misc_valid(spl_misc_valid), .misc_ready(spl_misc_ready), .misc_beat(spl_misc_beat),
		.route_valid(spl_route_valid), .route_ready(spl_route_ready), .route(spl_route)
	);

	stream_fifo #(.depth(fifo_depth), .payload_t(sign_crypt_pkg::stream_beat_t)) i_vid_fifo (
		.clk(clk), .rst_n_200(rst_n_200),
		.in_valid(spl_vid_valid), .in_ready(spl_vid_ready), .in_data(spl_vid_beat),
		.out_valid(vid_valid), .out_ready(vid_ready), .out_data(vid_beat)
	);

	stream_fifo #(.depth(fifo_depth), .payload_t(sign_crypt_pkg::stream_beat_t)) i_misc_fifo (
		.clk(clk), .rst_n_200(rst_n_200),
		.in_valid(spl_misc_valid), .in_ready(spl_misc_ready), .in_data(spl_misc_beat),
		.out_valid(misc_valid), .out_ready(misc_ready), .out_data(misc_beat)
	);

	stream_fifo #(.depth(fifo_depth), .payload_t(sign_crypt_pkg::route_t)) i_order_fifo (
		.clk(clk), .rst_n_200(rst_n_200),
		.in_valid(spl_route_valid), .in_ready(spl_route_ready), .in_data(spl_route),
		.out_valid(ord_valid), .out_ready(ord_ready), .out_data(ord_route)
	);

	sign_scrambler i_scrambler (
		.clk(clk), .rst_n_200(rst_n_200),
		.key_in(key_in), .key_en(key_en),
		.in_valid(vid_valid), .in_ready(vid_ready), .in_beat(vid_beat),
		.out_valid(enc_valid), .out_ready(enc_ready), .out_beat(enc_beat)
	);

	stream_fifo #(.depth(fifo_depth), .payload_t(sign_crypt_pkg::stream_beat_t)) i_scr_fifo (
		.clk(clk), .rst_n_200(rst_n_200),
		.in_valid(enc_valid), .in_ready(enc_ready), .in_data(enc_beat),
		.out_valid(scr_valid), .out_ready(scr_ready), .out_data(scr_beat)
	);

	joiner i_joiner (
		.clk(clk), .rst_n_200(rst_n_200),
		.route_valid(ord_valid), .route_ready(ord_ready), .route(ord_route),
		.vid_valid(scr_valid), .vid_ready(scr_ready), .vid_beat(scr_beat),
		.misc_valid(misc_valid), .misc_ready(misc_ready), .misc_beat(misc_beat),
		.out_valid(join_valid), .out_ready(join_ready), .out_beat(join_beat)
	);

	stream_fifo #(.depth(fifo_depth), .payload_t(sign_crypt_pkg::stream_beat_t)) i_out_fifo (
		.clk(clk), .rst_n_200(rst_n_200),
		.in_valid(join_valid), .in_ready(join_ready), .in_data(join_beat),
		.out_valid(out_valid), .out_ready(out_ready), .out_data(out_beat)
	);

endmodule

//--- tb/video_sign_crypt_props.sv
// handshake checks at the top level ports; sampled on the rising edge, quiet while reset is low
`timescale 1ns/100ps

module video_sign_crypt_props (
	input logic clk,
	input logic rst_n_200,
	input logic in_valid,
	input logic in_ready,
	input sign_crypt_pkg::tagged_beat_t in_beat,
	input logic out_valid,
	input logic out_ready,
	input sign_crypt_pkg::stream_beat_t out_beat
);

	int assert_fails = 0;

	// a stalled input beat stays offered and unchanged
	in_hold: assert property (@(posedge clk) disable iff (!rst_n_200)
		in_valid && !in_ready |=> in_valid && $stable(in_beat))
	else begin
		$error("input beat dropped or changed before in_ready");
		assert_fails++;
	end

	// same rule on the output side
	out_hold: assert property (@(posedge clk) disable iff (!rst_n_200)
		out_valid && !out_ready |=> out_valid && $stable(out_beat))
	else begin
		$error("output beat dropped or changed before out_ready");
		assert_fails++;
	end

	out_low_in_reset: assert property (@(posedge clk) !rst_n_200 |=> !out_valid)
	else begin
		$error("out_valid high after a reset cycle");
		assert_fails++;
	end

endmodule

//--- tb/video_sign_crypt_tb.sv
// random mixed streams with input gaps, output gaps and a full stall; streams end on a video byte
`timescale 1ns/100ps

module video_sign_crypt_tb;

	localparam int wait_limit = 400;

	logic clk;
	logic rst_n_200;
	logic in_valid;
	logic in_ready;
	sign_crypt_pkg::tagged_beat_t in_beat;
	logic out_valid;
	logic out_ready;
	sign_crypt_pkg::stream_beat_t out_beat;
	logic [sign_crypt_pkg::key_w-1:0] key_in;
	logic key_en;

	integer seed;
	integer ready_seed;
	// 0 always ready, 1 random gaps, 2 held low
	int ready_mode;
	int mode_now;
	int mismatches;
	int timeouts;
	int flow_errors;
	int exp_rd;

	// reference state
	logic [sign_crypt_pkg::key_w-1:0] ref_key;
	int ref_idx;
	sign_crypt_pkg::stream_beat_t exp_q[$];

	video_sign_crypt i_dut (
		.clk(clk), .rst_n_200(rst_n_200),
		.in_valid(in_valid), .in_ready(in_ready), .in_beat(in_beat),
		.out_valid(out_valid), .out_ready(out_ready), .out_beat(out_beat),
		.key_in(key_in), .key_en(key_en)
	);

	bind video_sign_crypt video_sign_crypt_props i_props (
		.clk(clk), .rst_n_200(rst_n_200),
		.in_valid(in_valid), .in_ready(in_ready), .in_beat(in_beat),
		.out_valid(out_valid), .out_ready(out_ready), .out_beat(out_beat)
	);

	always #2 clk = ~clk;

	// misc bytes pass as is, video bytes get bit 0 flipped by the indexed key bit
	function automatic sign_crypt_pkg::stream_beat_t expect_beat(
		input sign_crypt_pkg::tagged_beat_t b
	);
		sign_crypt_pkg::stream_beat_t r;
		r = b.beat;
		if (b.is_video) begin
			r.data[0] = b.beat.data[0] ^ ref_key[ref_idx];
			ref_idx = b.beat.last ? 0 : (ref_idx + 1) % sign_crypt_pkg::key_w;
		end
		return r;
	endfunction

	function automatic sign_crypt_pkg::tagged_beat_t random_beat(input int video_pct);
		sign_crypt_pkg::tagged_beat_t b;
		b.beat.data = 8'($random(seed));
		b.beat.last = 1'b0;
		b.is_video = (($random(seed) & 32'h7fff_ffff) % 100) < video_pct;
		return b;
	endfunction

	// output side, sampled at the falling edge where everything is settled
	always @(negedge clk) begin
		if (rst_n_200 && out_valid && out_ready) begin
			if (exp_rd >= exp_q.size()) begin
				$display("Fail at %0t: unexpected output beat %h", $time, out_beat);
				mismatches++;
			end else if (out_beat !== exp_q[exp_rd]) begin
				$display("Fail at %0t: beat %0d got data %h last %b, expected data %h last %b",
					$time, exp_rd, out_beat.data, out_beat.last,
					exp_q[exp_rd].data, exp_q[exp_rd].last);
				mismatches++;
			end
			exp_rd++;
		end
	end

	always @(posedge clk) begin
		mode_now = ready_mode;
		#1;
		if (mode_now == 2) begin
			out_ready = 1'b0;
		end else if (mode_now == 1) begin
			out_ready = (($random(ready_seed) & 32'd3) != 32'd0);
		end else begin
			out_ready = 1'b1;
		end
	end

	task automatic send_beat(input sign_crypt_pkg::tagged_beat_t b);
		int waited;
		waited = 0;
		in_valid = 1'b1;
		in_beat = b;
		@(negedge clk);
		while (!in_ready && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (!in_ready) begin
			$display("timeout: in_ready stayed low for %0d cycles at %0t", wait_limit, $time);
			timeouts++;
		end else begin
			exp_q.push_back(expect_beat(b));
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic send_stream(input int len, input int video_pct);
		sign_crypt_pkg::tagged_beat_t b;
		for (int i = 0; i < len && timeouts == 0; i++) begin
			b = random_beat(video_pct);
			if (i == len - 1) begin
				b.is_video = 1'b1;
				b.beat.last = 1'b1;
			end
			send_beat(b);
			if (($random(seed) & 32'd3) == 32'd0) begin
				@(posedge clk);
				#1;
			end
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_rd < exp_q.size() && waited < wait_limit) begin
			@(posedge clk);
			waited++;
		end
		if (exp_rd < exp_q.size()) begin
			$display("timeout: %0d expected beats never came out", exp_q.size() - exp_rd);
			timeouts++;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic load_key(input logic [sign_crypt_pkg::key_w-1:0] k);
		wait_drain();
		key_in = k;
		key_en = 1'b1;
		ref_key = k;
		@(posedge clk);
		#1;
		key_en = 1'b0;
	endtask

	// hold the output low until every FIFO backs up to the input
	task automatic fill_while_stalled();
		sign_crypt_pkg::tagged_beat_t b;
		int sent;
		logic full_seen;
		sent = 0;
		full_seen = 1'b0;
		ready_mode = 2;
		while (!full_seen && sent < wait_limit) begin
			b = random_beat(50);
			in_valid = 1'b1;
			in_beat = b;
			@(negedge clk);
			if (in_ready) begin
				exp_q.push_back(expect_beat(b));
				sent++;
				@(posedge clk);
				#1;
			end else begin
				full_seen = 1'b1;
			end
		end
		ready_mode = 1;
		if (!full_seen) begin
			$display("in_ready never fell with the output held back");
			flow_errors++;
			in_valid = 1'b0;
		end else begin
			@(posedge clk);
			#1;
			send_beat(b);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n_200 = 1'b0;
		in_valid = 1'b0;
		in_beat = '0;
		out_ready = 1'b0;
		key_in = '0;
		key_en = 1'b0;
		seed = 42081;
		ready_seed = $random(seed);
		ready_mode = 0;
		mismatches = 0;
		timeouts = 0;
		flow_errors = 0;
		exp_rd = 0;
		ref_key = '0;
		ref_idx = 0;
		repeat (2) @(posedge clk);
		#1;
		rst_n_200 = 1'b1;

		// zero key leaves every byte as it came in
		send_stream(24, 50);
		load_key({$random(seed), $random(seed)});
		send_stream(40, 60);
		// long all video stream wraps the index, next stream restarts at bit 0
		send_stream(140, 100);
		send_stream(30, 70);
		ready_mode = 1;
		send_stream(80, 50);
		fill_while_stalled();
		wait_drain();
		ready_mode = 0;
		load_key({$random(seed), $random(seed)});
		send_stream(50, 60);
		wait_drain();

		$display("errors: %0d mismatches, %0d timeouts, %0d flow, %0d assertion, %0d beats checked",
			mismatches, timeouts, flow_errors, i_dut.i_props.assert_fails, exp_rd);
		if (mismatches + timeouts + flow_errors + i_dut.i_props.assert_fails == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- video_sign_crypt.f
logic/sign_crypt_pkg.sv
logic/stream_fifo.sv
logic/splitter.sv
logic/sign_scrambler.sv
logic/joiner.sv
logic/video_sign_crypt.sv
tb/video_sign_crypt_props.sv
tb/video_sign_crypt_tb.sv

//--- Makefile
# Verilator build and run of the video_sign_crypt testbench

VERILATOR ?= verilator
TOP ?= video_sign_crypt_tb
FILELIST ?= video_sign_crypt.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$($(SIM)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
